// ==== mmio_defs.svh ====
`ifndef MMIO_DEFS_SVH
`define MMIO_DEFS_SVH

// width of the decoded register offset
`define MMIO_ADDR_W 16

// register map, low 16 address bits
`define MMIO_HALT      16'h0000
`define MMIO_TO_HOST   16'h0004
`define MMIO_FROM_HOST 16'h0008
`define MMIO_LED       16'h000C
`define MMIO_SEG7      16'h0010
`define MMIO_BTN       16'h0014
`define MMIO_SW        16'h0018
`define MMIO_LFSR      16'h001C
`define MMIO_CPU_FREQ  16'h0020
`define MMIO_BP_HIT    16'h0024
`define MMIO_BP_PRED   16'h0028
`define MMIO_DC_HIT    16'h002C
`define MMIO_DC_ACCESS 16'h0030

// top-level defaults
`define MMIO_CPU_FREQ_DEF 100000000
`define MMIO_BAUD_DEF     1000000

// any nonzero value works, zero would lock up
`define MMIO_LFSR_SEED 32'h1

`endif

// ==== mmio_pkg.sv ====
`include "mmio_defs.svh"

package mmio_pkg;

  // cpu data port request, one-cycle strobe
  typedef struct packed {
    logic                    en;
    logic                    we;
    logic [`MMIO_ADDR_W-1:0] addr;
    logic [31:0]             wdata;
  } mmio_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } mmio_rsp_t;

  // external performance counters
  typedef struct packed {
    logic [31:0] bp_hit;
    logic [31:0] bp_pred;
    logic [31:0] dc_hit;
    logic [31:0] dc_access;
  } perf_cnt_t;

  typedef struct packed {
    logic        halt;
    logic [15:0] led;
    logic [31:0] seg7;
  } board_out_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } uart_rx_state_t;

endpackage

// ==== uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx import mmio_pkg::*; #(
  parameter int unsigned CLKS_PER_BIT = 100
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] data,
  input  logic       start,
  output logic       txd,
  output logic       ready
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);

  uart_tx_state_t   state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shreg;
  logic             bit_end;

  assign bit_end = (cnt == LAST);
  assign ready   = (state == TX_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= TX_IDLE;
      txd     <= 1'b1;  // line idles high
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      cnt <= (state == TX_IDLE || bit_end) ? '0 : cnt + 1'b1;
      case (state)
        TX_IDLE: if (start) begin  // start while busy is dropped
          state <= TX_START;
          txd   <= 1'b0;
        end
        TX_START: if (bit_end) begin
          state   <= TX_DATA;
          txd     <= shreg[0];
          bit_idx <= '0;
        end
        TX_DATA: if (bit_end) begin
          if (bit_idx == 3'd7) begin
            state <= TX_STOP;
            txd   <= 1'b1;
          end else begin
            txd     <= shreg[0];
            bit_idx <= bit_idx + 1'b1;
          end
        end
        TX_STOP: if (bit_end) state <= TX_IDLE;
        default: state <= TX_IDLE;
      endcase
    end
  end

  // lsb first, next bit always in shreg[0]
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && start)
      shreg <= data;
    else if (bit_end && (state == TX_START || state == TX_DATA))
      shreg <= {1'b1, shreg[7:1]};
  end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx import mmio_pkg::*; #(
  parameter int unsigned CLKS_PER_BIT = 100
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       rxd,
  output logic [7:0] data,
  output logic       valid
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF = CNT_W'(CLKS_PER_BIT / 2);

  uart_rx_state_t   state;
  logic [1:0]       sync;
  logic             rxd_s;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shreg;

  // two-flop synchronizer, resets to idle level
  always_ff @(posedge clk) begin
    if (rst)
      sync <= 2'b11;
    else
      sync <= {sync[0], rxd};
  end
  assign rxd_s = sync[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= RX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      valid   <= 1'b0;
    end else begin
      valid <= 1'b0;
      cnt   <= cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (!rxd_s) state <= RX_START;
        end
        RX_START: if (cnt == HALF) begin  // mid start bit
          cnt     <= '0;
          bit_idx <= '0;
          state   <= rxd_s ? RX_IDLE : RX_DATA;  // glitch, back to idle
        end
        RX_DATA: if (cnt == LAST) begin
          cnt     <= '0;
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) state <= RX_STOP;
        end
        RX_STOP: if (cnt == LAST) begin
          state <= RX_IDLE;
          valid <= rxd_s;  // no pulse on a bad stop bit
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // sample at mid-bit, lsb arrives first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && cnt == LAST)
      shreg <= {rxd_s, shreg[7:1]};
    if (state == RX_STOP && cnt == LAST && rxd_s)
      data <= shreg;
  end

endmodule

// ==== mmio_regs.sv ====
`timescale 1ns/10ps
`include "mmio_defs.svh"

module mmio_regs import mmio_pkg::*; #(
  parameter int unsigned CPU_FREQ = `MMIO_CPU_FREQ_DEF
) (
  input  logic       clk,
  input  logic       rst,
  input  mmio_req_t  req,
  output mmio_rsp_t  rsp,
  input  logic [4:0] btn,  // {down, right, left, up, center}
  input  logic [15:0] sw,
  input  perf_cnt_t  perf,
  output board_out_t board,
  output logic [7:0] tx_data,
  output logic       tx_start,
  input  logic       tx_ready,
  input  logic [7:0] rx_data,
  input  logic       rx_valid
);

  // galois form of x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic        wr;
  logic        rd;
  logic        unread;
  logic [7:0]  rx_hold;
  logic [31:0] lfsr;
  logic [31:0] rd_mux;
  logic        rsp_valid;
  logic [31:0] rsp_rdata;

  assign wr = req.en & req.we;
  assign rd = req.en & ~req.we;

  // control and output registers
  always_ff @(posedge clk) begin
    if (rst) begin
      board    <= '0;
      tx_start <= 1'b0;
      unread   <= 1'b0;
    end else begin
      tx_start <= wr && (req.addr == `MMIO_TO_HOST);  // one-cycle pulse
      if (wr) begin
        case (req.addr)
          `MMIO_HALT: board.halt <= 1'b1;  // sticky until reset
          `MMIO_LED:  board.led  <= req.wdata[15:0];
          `MMIO_SEG7: board.seg7 <= req.wdata;
          default: ;
        endcase
      end
      // software ack beats a byte landing in the same cycle
      if (wr && (req.addr == `MMIO_FROM_HOST))
        unread <= 1'b0;
      else if (rx_valid)
        unread <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr && (req.addr == `MMIO_TO_HOST))
      tx_data <= req.wdata[7:0];
    if (rx_valid)
      rx_hold <= rx_data;  // held even if unread is being cleared
  end

  // free-running random source
  always_ff @(posedge clk) begin
    if (rst)
      lfsr <= `MMIO_LFSR_SEED;
    else
      lfsr <= {1'b0, lfsr[31:1]} ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
  end

  always_comb begin
    case (req.addr)
      `MMIO_TO_HOST:   rd_mux = {31'h0, tx_ready};
      `MMIO_FROM_HOST: rd_mux = {~unread, 23'h0, rx_hold};  // bit 31 set = empty
      `MMIO_BTN:       rd_mux = {27'h0, btn};
      `MMIO_SW:        rd_mux = {16'h0, sw};
      `MMIO_LFSR:      rd_mux = lfsr;
      `MMIO_CPU_FREQ:  rd_mux = 32'(CPU_FREQ);
      `MMIO_BP_HIT:    rd_mux = perf.bp_hit;
      `MMIO_BP_PRED:   rd_mux = perf.bp_pred;
      `MMIO_DC_HIT:    rd_mux = perf.dc_hit;
      `MMIO_DC_ACCESS: rd_mux = perf.dc_access;
      default:         rd_mux = 32'h0;
    endcase
  end

  // read response, one cycle after the strobe
  always_ff @(posedge clk) begin
    if (rst)
      rsp_valid <= 1'b0;
    else
      rsp_valid <= rd;
  end

  always_ff @(posedge clk) begin
    if (rd)
      rsp_rdata <= rd_mux;
  end

  assign rsp.valid = rsp_valid;
  assign rsp.rdata = rsp_rdata;

endmodule

// ==== mmio_top.sv ====
`timescale 1ns/10ps
`include "mmio_defs.svh"

module mmio_top import mmio_pkg::*; #(
  parameter int unsigned CPU_FREQ = `MMIO_CPU_FREQ_DEF,
  parameter int unsigned BAUDRATE = `MMIO_BAUD_DEF
) (
  input  logic       clk,
  input  logic       rst,
  input  mmio_req_t  req,
  output mmio_rsp_t  rsp,
  input  logic       uart_rxd,
  output logic       uart_txd,
  input  logic [4:0] btn,
  input  logic [15:0] sw,
  input  perf_cnt_t  perf,
  output board_out_t board,
  output logic [7:0] rx_data,   // raw byte for the host loader
  output logic       rx_valid
);

  localparam int unsigned CLKS_PER_BIT = CPU_FREQ / BAUDRATE;

  logic [7:0] tx_data;
  logic       tx_start;
  logic       tx_ready;

  mmio_regs #(
    .CPU_FREQ (CPU_FREQ)
  ) u_regs (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .rsp      (rsp),
    .btn      (btn),
    .sw       (sw),
    .perf     (perf),
    .board    (board),
    .tx_data  (tx_data),
    .tx_start (tx_start),
    .tx_ready (tx_ready),
    .rx_data  (rx_data),
    .rx_valid (rx_valid)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk   (clk),
    .rst   (rst),
    .data  (tx_data),
    .start (tx_start),
    .txd   (uart_txd),
    .ready (tx_ready)
  );

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk   (clk),
    .rst   (rst),
    .rxd   (uart_rxd),
    .data  (rx_data),
    .valid (rx_valid)
  );

endmodule

// ==== tb_mmio.sv ====
`timescale 1ns/10ps
`include "mmio_defs.svh"

module tb_mmio import mmio_pkg::*; ();

  logic        clk;
  logic        rst;
  mmio_req_t   req;
  mmio_rsp_t   rsp;
  logic        serial;  // txd looped back to rxd
  logic [4:0]  btn;
  logic [15:0] sw;
  perf_cnt_t   perf;
  board_out_t  board;
  logic [7:0]  rx_data;
  logic        rx_valid;
  logic [31:0] lcg_state = 32'd93234;
  int          rx_count = 0;
  logic [7:0]  rx_byte = 8'h0;

  mmio_top #(
    .CPU_FREQ (1000000),
    .BAUDRATE (100000)
  ) UUT (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .rsp      (rsp),
    .uart_rxd (serial),
    .uart_txd (serial),
    .btn      (btn),
    .sw       (sw),
    .perf     (perf),
    .board    (board),
    .rx_data  (rx_data),
    .rx_valid (rx_valid)
  );

  always #10 clk = ~clk;

  // host side counts the raw byte pulses
  always @(negedge clk) begin
    if (rx_valid) begin
      rx_count <= rx_count + 1;
      rx_byte  <= rx_data;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
    @(negedge clk);
    req.en    = 1'b1;
    req.we    = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    @(negedge clk);  // request edge has passed
    req.en = 1'b0;
    req.we = 1'b0;
    check_eq("rsp.valid", {31'h0, rsp.valid}, 32'h0);  // writes give no response
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
    @(negedge clk);
    req.en    = 1'b1;
    req.we    = 1'b0;
    req.addr  = addr;
    req.wdata = 32'h0;
    @(negedge clk);
    req.en = 1'b0;
    check_eq("rsp.valid", {31'h0, rsp.valid}, 32'h1);
    data = rsp.rdata;
  endtask

  task automatic wait_tx_ready(input logic level);
    logic [31:0] v;
    int polls;
    polls = 0;
    bus_read(`MMIO_TO_HOST, v);
    while (v[0] !== level) begin
      polls++;
      if (polls > 400) begin
        $display("timeout while polling TO_HOST for tx_ready %0d", level);
        abort_run();
      end
      bus_read(`MMIO_TO_HOST, v);
    end
  endtask

  task automatic send_byte(input logic [7:0] b);
    bus_write(`MMIO_TO_HOST, {24'h0, b});
    wait_tx_ready(1'b0);
    wait_tx_ready(1'b1);
  endtask

  task automatic wait_rx(input int count);
    int cycles;
    cycles = 0;
    while (rx_count < count) begin
      @(negedge clk);
      cycles++;
      if (cycles > 300) begin
        $display("timeout waiting for a received byte on rx_valid");
        abort_run();
      end
    end
  endtask

  task automatic reset_and_writes();
    logic [31:0] v;
    logic [31:0] r;
    check_eq("board.halt", {31'h0, board.halt}, 32'h0);
    check_eq("board.led", {16'h0, board.led}, 32'h0);
    check_eq("board.seg7", board.seg7, 32'h0);
    check_eq("rsp.valid", {31'h0, rsp.valid}, 32'h0);
    check_eq("uart_txd", {31'h0, serial}, 32'h1);  // line idles high
    bus_read(`MMIO_TO_HOST, v);
    check_eq("to_host", v, 32'h1);
    r = next_rand();
    bus_write(`MMIO_LED, r);
    check_eq("board.led", {16'h0, board.led}, {16'h0, r[15:0]});
    r = next_rand();
    bus_write(`MMIO_SEG7, r);
    check_eq("board.seg7", board.seg7, r);
    check_eq("board.halt", {31'h0, board.halt}, 32'h0);
    bus_write(`MMIO_HALT, 32'h0);
    check_eq("board.halt", {31'h0, board.halt}, 32'h1);
  endtask

  task automatic inputs_and_constants();
    logic [31:0] v;
    logic [31:0] r;
    @(negedge clk);
    r = next_rand();
    btn = r[4:0];
    sw  = r[31:16];
    perf.bp_hit    = next_rand();
    perf.bp_pred   = next_rand();
    perf.dc_hit    = next_rand();
    perf.dc_access = next_rand();
    bus_read(`MMIO_BTN, v);
    check_eq("btn", v, {27'h0, btn});
    bus_read(`MMIO_SW, v);
    check_eq("sw", v, {16'h0, sw});
    bus_read(`MMIO_BP_HIT, v);
    check_eq("bp_hit", v, perf.bp_hit);
    bus_read(`MMIO_BP_PRED, v);
    check_eq("bp_pred", v, perf.bp_pred);
    bus_read(`MMIO_DC_HIT, v);
    check_eq("dc_hit", v, perf.dc_hit);
    bus_read(`MMIO_DC_ACCESS, v);
    check_eq("dc_access", v, perf.dc_access);
    bus_read(`MMIO_CPU_FREQ, v);
    check_eq("cpu_freq", v, 32'd1000000);
    bus_read(16'h0040, v);  // unmapped
    check_eq("unmapped", v, 32'h0);
  endtask

  task automatic uart_loopback();
    logic [31:0] v;
    logic [31:0] r;
    int n0;
    r  = next_rand();
    n0 = rx_count;
    send_byte(r[7:0]);
    wait_rx(n0 + 1);
    check_eq("rx_count", rx_count, n0 + 1);
    check_eq("rx_data", {24'h0, rx_byte}, {24'h0, r[7:0]});
    bus_read(`MMIO_FROM_HOST, v);
    check_eq("from_host", v, {24'h0, r[7:0]});
    bus_write(`MMIO_FROM_HOST, 32'h0);
    bus_read(`MMIO_FROM_HOST, v);
    check_eq("from_host", v, {1'b1, 23'h0, r[7:0]});  // empty again
  endtask

  task automatic receive_hold();
    logic [31:0] v;
    logic [31:0] r;
    int n0;
    r  = next_rand();
    if (r[15:8] == r[7:0])
      r[15:8] = ~r[7:0];  // second byte must differ from the first
    n0 = rx_count;
    send_byte(r[7:0]);
    send_byte(r[15:8]);
    wait_rx(n0 + 2);
    bus_read(`MMIO_FROM_HOST, v);
    check_eq("from_host", v, {24'h0, r[15:8]});
  endtask

  task automatic lfsr_reads();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    bus_read(`MMIO_LFSR, a);
    bus_read(`MMIO_LFSR, b);
    bus_read(`MMIO_LFSR, c);
    check_eq("lfsr_a_nonzero", {31'h0, a != 32'h0}, 32'h1);
    check_eq("lfsr_b_nonzero", {31'h0, b != 32'h0}, 32'h1);
    check_eq("lfsr_c_nonzero", {31'h0, c != 32'h0}, 32'h1);
    check_eq("lfsr_a_ne_b", {31'h0, a != b}, 32'h1);
    check_eq("lfsr_b_ne_c", {31'h0, b != c}, 32'h1);
    check_eq("lfsr_a_ne_c", {31'h0, a != c}, 32'h1);
  endtask

  initial begin
    clk  = 1'b0;
    rst  = 1'b1;
    req  = '0;
    btn  = '0;
    sw   = '0;
    perf = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    reset_and_writes();
    inputs_and_constants();
    uart_loopback();
    receive_hold();
    lfsr_reads();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== mmio_top.f ====
+incdir+.
mmio_pkg.sv
uart_tx.sv
uart_rx.sv
mmio_regs.sv
mmio_top.sv
tb_mmio.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f mmio_top.f --top-module tb_mmio -o tb_mmio &&
./obj_dir/tb_mmio ||
{ echo "simulation did not pass"; exit 1; }
